// ==== rtl/ceres_pkg.sv ====
// Shared definitions for the two-stage RV32I core
// Widths, opcode and retire-operation encodings, bus ownership
`default_nettype none

package ceres_pkg;

  // Data and address width
  localparam int XLEN = 32;
  // Architectural register count
  localparam int NUM_REGS = 32;

  // Major opcode field of the kept instructions
  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_e;

  // Operation retired by the execute stage
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_LW,
    ALU_SW,
    ALU_BEQ,
    ALU_BNE,
    ALU_JAL,
    ALU_NOP
  } alu_op_e;

  // Current owner of the external memory bus
  typedef enum logic [1:0] {
    OWN_IDLE,
    OWN_FETCH,
    OWN_DATA
  } bus_owner_e;

endpackage

`default_nettype wire

// ==== rtl/reg_file.sv ====
// Integer register file, 2 read ports and 1 write port
// x0 reads as zero and ignores writes
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [4:0]                 raddr1_i,
  input  logic [4:0]                 raddr2_i,
  output logic [ceres_pkg::XLEN-1:0] rdata1_o,
  output logic [ceres_pkg::XLEN-1:0] rdata2_o,
  input  logic                       we_i,
  input  logic [4:0]                 waddr_i,
  input  logic [ceres_pkg::XLEN-1:0] wdata_i
);
  import ceres_pkg::*;

  logic [XLEN-1:0] regs_q [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads, a write shows up the next cycle
  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];

  a_x0_zero: assert property (@(posedge clk_i) disable iff (!rst_ni) regs_q[0] == '0)
    else $error("register x0 lost its zero value");

endmodule

`default_nettype wire

// ==== rtl/decoder.sv ====
// RV32I decoder for the kept instruction subset
// Gives the retire operation, register fields and sign-extended immediate
`timescale 1ns/1ns
`default_nettype none

module decoder (
  input  logic [ceres_pkg::XLEN-1:0] inst_i,
  output ceres_pkg::alu_op_e         op_o,
  output logic [4:0]                 rs1_o,
  output logic [4:0]                 rs2_o,
  output logic [4:0]                 rd_o,
  output logic [ceres_pkg::XLEN-1:0] imm_o
);
  import ceres_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign rs1_o  = inst_i[19:15];
  assign rd_o   = inst_i[11:7];

  always_comb begin
    // Unknown encodings fall through as a no-op
    op_o  = ALU_NOP;
    imm_o = '0;
    // I-type reads x0 as its second source
    rs2_o = '0;
    case (opcode)
      OP_REG: begin
        rs2_o = inst_i[24:20];
        case ({funct7, funct3})
          {7'h00, 3'b000}: op_o = ALU_ADD;
          {7'h20, 3'b000}: op_o = ALU_SUB;
          {7'h00, 3'b111}: op_o = ALU_AND;
          {7'h00, 3'b110}: op_o = ALU_OR;
          {7'h00, 3'b100}: op_o = ALU_XOR;
          default:         op_o = ALU_NOP;
        endcase
      end
      OP_IMM: begin
        // ADDI only
        if (funct3 == 3'b000) begin
          op_o = ALU_ADD;
        end
        imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
      end
      OP_LOAD: begin
        if (funct3 == 3'b010) begin
          op_o = ALU_LW;
        end
        imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
      end
      OP_STORE: begin
        rs2_o = inst_i[24:20];
        if (funct3 == 3'b010) begin
          op_o = ALU_SW;
        end
        imm_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
      end
      OP_BRANCH: begin
        rs2_o = inst_i[24:20];
        if (funct3 == 3'b000) begin
          op_o = ALU_BEQ;
        end else if (funct3 == 3'b001) begin
          op_o = ALU_BNE;
        end
        // B-type offset, bit 0 always zero
        imm_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                 inst_i[11:8], 1'b0};
      end
      OP_JAL: begin
        op_o  = ALU_JAL;
        imm_o = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                 inst_i[30:21], 1'b0};
      end
      default: begin
        op_o = ALU_NOP;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
// Instruction fetch for the two-stage core
// Walks the PC by 4, keeps one prefetched word and restarts on a redirect
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
  parameter logic [ceres_pkg::XLEN-1:0] RESET_VECTOR = '0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  output logic                       if_req_o,
  output logic [ceres_pkg::XLEN-1:0] if_addr_o,
  input  logic                       if_done_i,
  input  logic [ceres_pkg::XLEN-1:0] rdata_i,
  output logic                       inst_valid_o,
  output logic [ceres_pkg::XLEN-1:0] inst_o,
  output logic [ceres_pkg::XLEN-1:0] inst_pc_o,
  input  logic                       inst_take_i,
  input  logic                       redirect_i,
  input  logic [ceres_pkg::XLEN-1:0] redirect_pc_i
);
  import ceres_pkg::*;

  logic            run_q;
  logic [XLEN-1:0] pc_q;
  logic            discard_q;
  logic [XLEN-1:0] target_q;
  logic            buf_valid_q;
  logic [XLEN-1:0] buf_inst_q;
  logic [XLEN-1:0] buf_pc_q;
  logic            keep_word;

  // One request is always open once out of reset
  assign if_req_o  = run_q;
  // Address only moves after the open fetch is done
  assign if_addr_o = pc_q;

  // Words from an overtaken path never reach the buffer
  assign keep_word = if_done_i && !discard_q && !redirect_i;

  // ========================================
  // PC and discard control
  // ========================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      run_q       <= 1'b0;
      pc_q        <= RESET_VECTOR;
      discard_q   <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (if_done_i) begin
        // Fetch finished, pick the next address
        if (redirect_i) begin
          pc_q <= redirect_pc_i;
        end else if (discard_q) begin
          pc_q <= target_q;
        end else begin
          pc_q <= pc_q + XLEN'(4);
        end
        discard_q <= 1'b0;
      end else if (redirect_i) begin
        // Fetch still on the bus, let it finish and drop it
        discard_q <= 1'b1;
      end
      // Buffer state, a redirect flushes it
      if (redirect_i) begin
        buf_valid_q <= 1'b0;
      end else if (keep_word) begin
        buf_valid_q <= 1'b1;
      end else if (inst_take_i) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // Buffered word and parked redirect target
  always_ff @(posedge clk_i) begin
    if (redirect_i) begin
      target_q <= redirect_pc_i;
    end
    if (keep_word) begin
      buf_inst_q <= rdata_i;
      buf_pc_q   <= pc_q;
    end
  end

  assign inst_valid_o = buf_valid_q;
  assign inst_o       = buf_inst_q;
  assign inst_pc_o    = buf_pc_q;

  // Fetch address holds until the arbiter reports done
  a_if_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    if_req_o && !if_done_i |=> $stable(if_addr_o))
    else $error("fetch address changed while request was open");

endmodule

`default_nettype wire

// ==== rtl/execute_unit.sv ====
// Execute and retire stage
// ALU work, branch and JAL resolution, register writes, load/store hand-off
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       inst_valid_i,
  input  logic [ceres_pkg::XLEN-1:0] inst_i,
  input  logic [ceres_pkg::XLEN-1:0] inst_pc_i,
  output logic                       inst_take_o,
  output logic                       redirect_o,
  output logic [ceres_pkg::XLEN-1:0] redirect_pc_o,
  output logic [4:0]                 rf_raddr1_o,
  output logic [4:0]                 rf_raddr2_o,
  input  logic [ceres_pkg::XLEN-1:0] rf_rdata1_i,
  input  logic [ceres_pkg::XLEN-1:0] rf_rdata2_i,
  output logic                       rf_we_o,
  output logic [4:0]                 rf_waddr_o,
  output logic [ceres_pkg::XLEN-1:0] rf_wdata_o,
  output logic                       ls_start_o,
  output logic                       ls_we_o,
  output logic [ceres_pkg::XLEN-1:0] ls_addr_o,
  output logic [ceres_pkg::XLEN-1:0] ls_wdata_o,
  input  logic                       ls_busy_i,
  input  logic                       ls_done_i,
  input  logic [ceres_pkg::XLEN-1:0] ls_rdata_i
);
  import ceres_pkg::*;

  alu_op_e         op;
  logic [4:0]      rd;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;
  logic            equal;
  logic            writes_rd;
  logic [4:0]      ld_rd_q;

  decoder i_decoder (
    .inst_i(inst_i),
    .op_o  (op),
    .rs1_o (rf_raddr1_o),
    .rs2_o (rf_raddr2_o),
    .rd_o  (rd),
    .imm_o (imm)
  );

  // No new instruction while a load or store is on its way
  assign inst_take_o = inst_valid_i && !ls_busy_i;

  // ========================================
  // ALU and branch compare
  // ========================================
  // R-type has a zero immediate and I-type reads x0, so one operand is zero
  assign op_b  = rf_rdata2_i | imm;
  assign equal = (rf_rdata1_i == rf_rdata2_i);

  always_comb begin
    case (op)
      ALU_ADD: alu_res = rf_rdata1_i + op_b;
      ALU_SUB: alu_res = rf_rdata1_i - op_b;
      ALU_AND: alu_res = rf_rdata1_i & op_b;
      ALU_OR:  alu_res = rf_rdata1_i | op_b;
      ALU_XOR: alu_res = rf_rdata1_i ^ op_b;
      // Link address
      ALU_JAL: alu_res = inst_pc_i + XLEN'(4);
      default: alu_res = '0;
    endcase
  end

  assign writes_rd = op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_JAL};

  // Taken branches and JAL restart fetch at pc + offset
  assign redirect_o = inst_take_o && ((op == ALU_JAL) || ((op == ALU_BEQ) && equal) ||
                                      ((op == ALU_BNE) && !equal));
  assign redirect_pc_o = inst_pc_i + imm;

  // ========================================
  // Load/store hand-off
  // ========================================
  assign ls_start_o = inst_take_o && ((op == ALU_LW) || (op == ALU_SW));
  assign ls_we_o    = (op == ALU_SW);
  assign ls_addr_o  = rf_rdata1_i + imm;
  assign ls_wdata_o = rf_rdata2_i;

  // Destination of the pending access, stores park x0 here
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ld_rd_q <= '0;
    end else if (ls_start_o) begin
      ld_rd_q <= (op == ALU_LW) ? rd : '0;
    end
  end

  // Write port, load data and ALU results never meet in one cycle
  always_comb begin
    rf_we_o    = 1'b0;
    rf_waddr_o = rd;
    rf_wdata_o = alu_res;
    if (ls_done_i) begin
      rf_we_o    = 1'b1;
      rf_waddr_o = ld_rd_q;
      rf_wdata_o = ls_rdata_i;
    end else if (inst_take_o && writes_rd) begin
      rf_we_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/load_store_unit.sv ====
// Load/store unit
// Latches one word access and carries it over the data port
`timescale 1ns/1ns
`default_nettype none

module load_store_unit (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       ls_start_i,
  input  logic                       ls_we_i,
  input  logic [ceres_pkg::XLEN-1:0] ls_addr_i,
  input  logic [ceres_pkg::XLEN-1:0] ls_wdata_i,
  output logic                       ls_busy_o,
  output logic                       ls_done_o,
  output logic [ceres_pkg::XLEN-1:0] ls_rdata_o,
  output logic                       bus_req_o,
  output logic                       bus_we_o,
  output logic [ceres_pkg::XLEN-1:0] bus_addr_o,
  output logic [ceres_pkg::XLEN-1:0] bus_wdata_o,
  input  logic                       bus_done_i,
  input  logic [ceres_pkg::XLEN-1:0] bus_rdata_i
);
  import ceres_pkg::*;

  logic            busy_q;
  logic            we_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] wdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (ls_start_i) begin
      busy_q <= 1'b1;
    end else if (bus_done_i) begin
      busy_q <= 1'b0;
    end
  end

  // Request fields with the address forced to a word boundary
  always_ff @(posedge clk_i) begin
    if (ls_start_i) begin
      we_q    <= ls_we_i;
      addr_q  <= ls_addr_i & ~XLEN'(3);
      wdata_q <= ls_wdata_i;
    end
  end

  // Fields stay put from start until done
  assign bus_req_o   = busy_q;
  assign bus_we_o    = we_q;
  assign bus_addr_o  = addr_q;
  assign bus_wdata_o = wdata_q;

  // Read data is valid in the done cycle itself
  assign ls_busy_o  = busy_q;
  assign ls_done_o  = busy_q && bus_done_i;
  assign ls_rdata_o = bus_rdata_i;

endmodule

`default_nettype wire

// ==== rtl/memory_arbiter.sv ====
// Memory bus arbiter
// Shares one bus between fetch and load/store, data side first
`timescale 1ns/1ns
`default_nettype none

module memory_arbiter (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       if_req_i,
  input  logic [ceres_pkg::XLEN-1:0] if_addr_i,
  output logic                       if_done_o,
  input  logic                       ls_req_i,
  input  logic                       ls_we_i,
  input  logic [ceres_pkg::XLEN-1:0] ls_addr_i,
  input  logic [ceres_pkg::XLEN-1:0] ls_wdata_i,
  output logic                       ls_done_o,
  output logic [ceres_pkg::XLEN-1:0] rdata_o,
  output logic                       mem_req_o,
  output logic                       mem_we_o,
  output logic [ceres_pkg::XLEN-1:0] mem_addr_o,
  output logic [ceres_pkg::XLEN-1:0] mem_wdata_o,
  input  logic [ceres_pkg::XLEN-1:0] mem_rdata_i,
  input  logic                       mem_ready_i
);
  import ceres_pkg::*;

  bus_owner_e owner_q;
  bus_owner_e owner;

  // An idle bus is granted in the request cycle
  always_comb begin
    if (owner_q != OWN_IDLE) begin
      owner = owner_q;
    end else if (ls_req_i) begin
      owner = OWN_DATA;
    end else if (if_req_i) begin
      owner = OWN_FETCH;
    end else begin
      owner = OWN_IDLE;
    end
  end

  // Owner holds until its access completes
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      owner_q <= OWN_IDLE;
    end else if (mem_ready_i) begin
      owner_q <= OWN_IDLE;
    end else begin
      owner_q <= owner;
    end
  end

  // ========================================
  // Bus drive from the owner
  // ========================================
  always_comb begin
    mem_req_o   = 1'b0;
    mem_we_o    = 1'b0;
    mem_addr_o  = '0;
    mem_wdata_o = '0;
    case (owner)
      OWN_FETCH: begin
        mem_req_o  = 1'b1;
        mem_addr_o = if_addr_i;
      end
      OWN_DATA: begin
        mem_req_o   = 1'b1;
        mem_we_o    = ls_we_i;
        mem_addr_o  = ls_addr_i;
        mem_wdata_o = ls_wdata_i;
      end
      default: begin
        mem_req_o = 1'b0;
      end
    endcase
  end

  assign if_done_o = (owner == OWN_FETCH) && mem_ready_i;
  assign ls_done_o = (owner == OWN_DATA) && mem_ready_i;
  assign rdata_o   = mem_rdata_i;

  a_one_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(if_done_o && ls_done_o))
    else $error("fetch and data completed in the same cycle");

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
// Top level of the two-stage RV32I core
// Fetch and load/store share the external bus through the arbiter
`timescale 1ns/1ns
`default_nettype none

module cpu_top #(
  parameter logic [ceres_pkg::XLEN-1:0] RESET_VECTOR = '0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  output logic                       mem_req_o,
  output logic                       mem_we_o,
  output logic [ceres_pkg::XLEN-1:0] mem_addr_o,
  output logic [ceres_pkg::XLEN-1:0] mem_wdata_o,
  input  logic [ceres_pkg::XLEN-1:0] mem_rdata_i,
  input  logic                       mem_ready_i
);
  import ceres_pkg::*;

  // Fetch port
  logic            if_req;
  logic [XLEN-1:0] if_addr;
  logic            if_done;
  // Data port
  logic            ls_req;
  logic            ls_we;
  logic [XLEN-1:0] ls_addr;
  logic [XLEN-1:0] ls_wdata;
  logic            ls_done;
  logic [XLEN-1:0] rdata;
  // Instruction hand-off
  logic            inst_valid;
  logic [XLEN-1:0] inst;
  logic [XLEN-1:0] inst_pc;
  logic            inst_take;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;
  // Register file
  logic [4:0]      rf_raddr1;
  logic [4:0]      rf_raddr2;
  logic [XLEN-1:0] rf_rdata1;
  logic [XLEN-1:0] rf_rdata2;
  logic            rf_we;
  logic [4:0]      rf_waddr;
  logic [XLEN-1:0] rf_wdata;
  // Execute to load/store
  logic            ex_ls_start;
  logic            ex_ls_we;
  logic [XLEN-1:0] ex_ls_addr;
  logic [XLEN-1:0] ex_ls_wdata;
  logic            ex_ls_busy;
  logic            ex_ls_done;
  logic [XLEN-1:0] ex_ls_rdata;

  fetch_unit #(
    .RESET_VECTOR(RESET_VECTOR)
  ) i_fetch_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .if_req_o     (if_req),
    .if_addr_o    (if_addr),
    .if_done_i    (if_done),
    .rdata_i      (rdata),
    .inst_valid_o (inst_valid),
    .inst_o       (inst),
    .inst_pc_o    (inst_pc),
    .inst_take_i  (inst_take),
    .redirect_i   (redirect),
    .redirect_pc_i(redirect_pc)
  );

  execute_unit i_execute_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .inst_valid_i (inst_valid),
    .inst_i       (inst),
    .inst_pc_i    (inst_pc),
    .inst_take_o  (inst_take),
    .redirect_o   (redirect),
    .redirect_pc_o(redirect_pc),
    .rf_raddr1_o  (rf_raddr1),
    .rf_raddr2_o  (rf_raddr2),
    .rf_rdata1_i  (rf_rdata1),
    .rf_rdata2_i  (rf_rdata2),
    .rf_we_o      (rf_we),
    .rf_waddr_o   (rf_waddr),
    .rf_wdata_o   (rf_wdata),
    .ls_start_o   (ex_ls_start),
    .ls_we_o      (ex_ls_we),
    .ls_addr_o    (ex_ls_addr),
    .ls_wdata_o   (ex_ls_wdata),
    .ls_busy_i    (ex_ls_busy),
    .ls_done_i    (ex_ls_done),
    .ls_rdata_i   (ex_ls_rdata)
  );

  reg_file i_reg_file (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .raddr1_i(rf_raddr1),
    .raddr2_i(rf_raddr2),
    .rdata1_o(rf_rdata1),
    .rdata2_o(rf_rdata2),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata)
  );

  load_store_unit i_load_store_unit (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ls_start_i (ex_ls_start),
    .ls_we_i    (ex_ls_we),
    .ls_addr_i  (ex_ls_addr),
    .ls_wdata_i (ex_ls_wdata),
    .ls_busy_o  (ex_ls_busy),
    .ls_done_o  (ex_ls_done),
    .ls_rdata_o (ex_ls_rdata),
    .bus_req_o  (ls_req),
    .bus_we_o   (ls_we),
    .bus_addr_o (ls_addr),
    .bus_wdata_o(ls_wdata),
    .bus_done_i (ls_done),
    .bus_rdata_i(rdata)
  );

  memory_arbiter i_memory_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .if_req_i   (if_req),
    .if_addr_i  (if_addr),
    .if_done_o  (if_done),
    .ls_req_i   (ls_req),
    .ls_we_i    (ls_we),
    .ls_addr_i  (ls_addr),
    .ls_wdata_i (ls_wdata),
    .ls_done_o  (ls_done),
    .rdata_o    (rdata),
    .mem_req_o  (mem_req_o),
    .mem_we_o   (mem_we_o),
    .mem_addr_o (mem_addr_o),
    .mem_wdata_o(mem_wdata_o),
    .mem_rdata_i(mem_rdata_i),
    .mem_ready_i(mem_ready_i)
  );

endmodule

`default_nettype wire

// ==== verification/rv_model.svh ====
// ISA model and random program generator for the core testbench
// Each program slot keeps its fields and the model runs from them
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

  localparam int          PROG_LEN  = 60;
  localparam int          DUMP_LEN  = 32;
  localparam int          LOOP_IDX  = PROG_LEN + DUMP_LEN;
  localparam logic [31:0] LOOP_ADDR = 32'(LOOP_IDX * 4);
  localparam logic [31:0] DATA_BASE = 32'h400;
  localparam logic [31:0] DUMP_BASE = 32'h600;

  // Instruction kinds of the random program
  // K_BAD stands for an unsupported encoding
  typedef enum logic [3:0] {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI,
    K_LW, K_SW, K_BEQ, K_BNE, K_JAL, K_BAD
  } kind_e;

  kind_e       p_kind [LOOP_IDX + 1];
  logic [4:0]  p_rd   [LOOP_IDX + 1];
  logic [4:0]  p_rs1  [LOOP_IDX + 1];
  logic [4:0]  p_rs2  [LOOP_IDX + 1];
  logic [31:0] p_imm  [LOOP_IDX + 1];
  // Architectural state of the model
  logic [31:0] m_regs [32];
  logic [31:0] m_mem  [MEM_WORDS];
  // Bus writes the model expects in program order
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];

  // Background word that depends on the whole address
  function automatic logic [31:0] fill_word(int idx);
    return (32'(idx) * 32'h9E37_79B1) ^ 32'h5AC3_0F96;
  endfunction

  // Machine word of one program slot in RV32I format
  function automatic logic [31:0] encode(int i);
    logic [31:0] imm;
    imm = p_imm[i];
    case (p_kind[i])
      K_ADD:  return {7'h00, p_rs2[i], p_rs1[i], 3'b000, p_rd[i], 7'b0110011};
      K_SUB:  return {7'h20, p_rs2[i], p_rs1[i], 3'b000, p_rd[i], 7'b0110011};
      K_AND:  return {7'h00, p_rs2[i], p_rs1[i], 3'b111, p_rd[i], 7'b0110011};
      K_OR:   return {7'h00, p_rs2[i], p_rs1[i], 3'b110, p_rd[i], 7'b0110011};
      K_XOR:  return {7'h00, p_rs2[i], p_rs1[i], 3'b100, p_rd[i], 7'b0110011};
      K_ADDI: return {imm[11:0], p_rs1[i], 3'b000, p_rd[i], 7'b0010011};
      // XORI is outside the kept set
      K_BAD:  return {imm[11:0], p_rs1[i], 3'b100, p_rd[i], 7'b0010011};
      K_LW:   return {imm[11:0], p_rs1[i], 3'b010, p_rd[i], 7'b0000011};
      K_SW:   return {imm[11:5], p_rs2[i], p_rs1[i], 3'b010, imm[4:0], 7'b0100011};
      K_BEQ:  return {imm[12], imm[10:5], p_rs2[i], p_rs1[i], 3'b000, imm[4:1],
                      imm[11], 7'b1100011};
      K_BNE:  return {imm[12], imm[10:5], p_rs2[i], p_rs1[i], 3'b001, imm[4:1],
                      imm[11], 7'b1100011};
      default: return {imm[20], imm[10:1], imm[11], imm[19:12], p_rd[i], 7'b1101111};
    endcase
  endfunction

  // ========================================
  // Program generator
  // ========================================
  task automatic build_program();
    int pick;
    int tgt;
    for (int i = 0; i < PROG_LEN; i++) begin
      pick      = rand_below(14);
      // ADDI gets extra weight so registers fill up with values
      p_kind[i] = (pick > 11) ? K_ADDI : kind_e'(4'(pick));
      p_rd[i]   = 5'(rand_below(32));
      p_rs1[i]  = 5'(rand_below(32));
      p_rs2[i]  = 5'(rand_below(32));
      p_imm[i]  = 32'(rand_below(4096) - 2048);
      // Forward target 2 to 4 slots ahead, clamped to the dump start
      tgt = i + 2 + rand_below(3);
      if (tgt > PROG_LEN) begin
        tgt = PROG_LEN;
      end
      if (p_kind[i] == K_LW || p_kind[i] == K_SW) begin
        // Base is x0 and the random low address bits are ignored
        p_rs1[i] = '0;
        p_imm[i] = DATA_BASE + 32'(4 * rand_below(16));
        p_imm[i] = p_imm[i] + 32'(rand_below(4));
      end else if (p_kind[i] inside {K_BEQ, K_BNE, K_JAL}) begin
        p_imm[i] = 32'(4 * (tgt - i));
      end
    end
    // Dump of x0..x31 followed by a jump to itself
    for (int r = 0; r < DUMP_LEN; r++) begin
      p_kind[PROG_LEN + r] = K_SW;
      p_rd[PROG_LEN + r]   = '0;
      p_rs1[PROG_LEN + r]  = '0;
      p_rs2[PROG_LEN + r]  = 5'(r);
      p_imm[PROG_LEN + r]  = DUMP_BASE + 32'(4 * r);
    end
    p_kind[LOOP_IDX] = K_JAL;
    p_rd[LOOP_IDX]   = '0;
    p_rs1[LOOP_IDX]  = '0;
    p_rs2[LOOP_IDX]  = '0;
    p_imm[LOOP_IDX]  = '0;
    // Same image for the bus memory and the model memory
    for (int w = 0; w < MEM_WORDS; w++) begin
      mem[w]   = (w <= LOOP_IDX) ? encode(w) : fill_word(w);
      m_mem[w] = mem[w];
    end
  endtask

  // ========================================
  // ISA model
  // ========================================
  task automatic run_model();
    int          pc;
    int          npc;
    int          steps;
    logic        wr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] res;
    for (int r = 0; r < 32; r++) begin
      m_regs[r] = '0;
    end
    pc    = 0;
    steps = 0;
    while (pc != LOOP_IDX && steps < 1000) begin
      a   = m_regs[p_rs1[pc]];
      b   = m_regs[p_rs2[pc]];
      // Word access drops the low two address bits
      ea  = (a + p_imm[pc]) & 32'hFFFF_FFFC;
      res = '0;
      wr  = 1'b1;
      npc = pc + 1;
      case (p_kind[pc])
        K_ADD:  res = a + b;
        K_SUB:  res = a - b;
        K_AND:  res = a & b;
        K_OR:   res = a | b;
        K_XOR:  res = a ^ b;
        K_ADDI: res = a + p_imm[pc];
        K_LW:   res = m_mem[ea[11:2]];
        K_JAL: begin
          res = 32'(4 * pc + 4);
          npc = pc + int'(p_imm[pc] >> 2);
        end
        K_SW: begin
          wr = 1'b0;
          m_mem[ea[11:2]] = b;
          exp_addr_q.push_back(ea);
          exp_data_q.push_back(b);
        end
        K_BEQ: begin
          wr = 1'b0;
          if (a == b) begin
            npc = pc + int'(p_imm[pc] >> 2);
          end
        end
        K_BNE: begin
          wr = 1'b0;
          if (a != b) begin
            npc = pc + int'(p_imm[pc] >> 2);
          end
        end
        // Unsupported encoding retires as a no-op
        default: wr = 1'b0;
      endcase
      if (wr && p_rd[pc] != 5'd0) begin
        m_regs[p_rd[pc]] = res;
      end
      pc = npc;
      steps++;
    end
  endtask

`endif

// ==== verification/cpu_tb.sv ====
// Testbench for the two-stage RV32I core
// Random program, memory with random latency, checks against an ISA model
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

  localparam logic [31:0] RESET_VECTOR = 32'h0;
  localparam int          MEM_WORDS    = 1024;
  localparam int          MAX_CYCLES   = 20000;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        mem_req_o;
  logic        mem_we_o;
  logic [31:0] mem_addr_o;
  logic [31:0] mem_wdata_o;
  logic [31:0] mem_rdata_i;
  logic        mem_ready_i;

  // Bus memory of 4 KiB
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] lcg_state = 32'd64389;

  // State of the access being served
  logic        bus_pending;
  int          bus_wait;
  logic        held_we;
  logic [31:0] held_addr;
  logic [31:0] held_wdata;

  // Error counts per test
  int err_reset = 0;
  int err_bus   = 0;
  int err_store = 0;
  int err_dump  = 0;
  int err_x0    = 0;
  int err_flow  = 0;
  int failed_tests = 0;
  int loop_reads   = 0;
  bit first_seen   = 1'b0;

  // Linear congruential generator
  // Upper bits only since the low ones repeat quickly
  function automatic int rand_below(int n);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[30:16]) % n;
  endfunction

  `include "rv_model.svh"

  cpu_top #(
    .RESET_VECTOR(RESET_VECTOR)
  ) i_cpu_top (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .mem_req_o  (mem_req_o),
    .mem_we_o   (mem_we_o),
    .mem_addr_o (mem_addr_o),
    .mem_wdata_o(mem_wdata_o),
    .mem_rdata_i(mem_rdata_i),
    .mem_ready_i(mem_ready_i)
  );

  always #50 clk_i = ~clk_i;

  // First access must read the reset vector
  // Fetches of the loop word are counted
  task automatic note_request();
    if (!first_seen) begin
      first_seen = 1'b1;
      assert (!mem_we_o && mem_addr_o == RESET_VECTOR) else begin
        err_reset++;
        $display("error reset_start: expected %h actual %h", RESET_VECTOR, mem_addr_o);
      end
    end
    if (!mem_we_o && mem_addr_o == LOOP_ADDR) begin
      loop_reads++;
    end
  endtask

  // Ready goes high and the DUT completes the access on the next edge
  task automatic finish_access();
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    mem_ready_i = 1'b1;
    mem_rdata_i = mem[held_addr[11:2]];
    if (held_we) begin
      mem[held_addr[11:2]] = held_wdata;
      assert (exp_addr_q.size() != 0) else begin
        err_store++;
        $display("store_order: unexpected bus write of %h to address %h",
                 held_wdata, held_addr);
      end
      if (exp_addr_q.size() != 0) begin
        exp_addr = exp_addr_q.pop_front();
        exp_data = exp_data_q.pop_front();
        assert (held_addr == exp_addr && held_wdata == exp_data) else begin
          err_store++;
          $display("error store_order: expected %h:%h actual %h:%h",
                   exp_addr, exp_data, held_addr, held_wdata);
        end
      end
    end
  endtask

  // ========================================
  // Bus slave with random latency
  // ========================================
  initial begin : bus_model
    bus_pending = 1'b0;
    bus_wait    = 0;
    held_we     = 1'b0;
    held_addr   = '0;
    held_wdata  = '0;
    mem_ready_i = 1'b0;
    mem_rdata_i = '0;
    forever begin
      @(posedge clk_i);
      #1;
      // Handshake closed on this edge
      if (mem_ready_i) begin
        mem_ready_i = 1'b0;
        bus_pending = 1'b0;
      end
      if (!rst_ni) begin
        assert (!mem_req_o) else begin
          err_reset++;
          $display("reset_start: request raised while reset was held");
        end
      end else if (mem_req_o) begin
        if (bus_pending) begin
          // Fields must hold until ready
          assert (mem_addr_o == held_addr && mem_we_o == held_we &&
                  mem_wdata_o == held_wdata) else begin
            err_bus++;
            $display("error bus_stable: expected %h actual %h",
                     {held_we, held_addr, held_wdata},
                     {mem_we_o, mem_addr_o, mem_wdata_o});
          end
        end else begin
          bus_pending = 1'b1;
          held_we     = mem_we_o;
          held_addr   = mem_addr_o;
          held_wdata  = mem_wdata_o;
          bus_wait    = rand_below(5);
          note_request();
        end
        if (bus_wait == 0) begin
          finish_access();
        end else begin
          bus_wait--;
        end
      end else begin
        // Request must stay up until ready
        assert (!bus_pending) else begin
          err_bus++;
          $display("bus_stable: request to %h dropped before ready", held_addr);
          bus_pending = 1'b0;
        end
      end
    end
  end

  task automatic report_test(string name, int errs);
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  // Dump area against the model's final registers
  task automatic check_dump();
    int base_idx;
    base_idx = int'(DUMP_BASE >> 2);
    for (int r = 1; r < 32; r++) begin
      assert (mem[base_idx + r] == m_regs[r]) else begin
        err_dump++;
        $display("error dump_values: x%0d expected %h actual %h", r, m_regs[r],
                 mem[base_idx + r]);
      end
    end
    assert (mem[base_idx] == 32'h0) else begin
      err_x0++;
      $display("error x0_zero: expected %h actual %h", 32'h0, mem[base_idx]);
    end
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin : main
    int cycles;
    int total;
    rst_ni = 1'b0;
    build_program();
    run_model();
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Third fetch of the loop word means JAL ran twice
    cycles = 0;
    while (loop_reads < 3 && cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    assert (loop_reads >= 3) else begin
      err_flow++;
      $display("control_flow: self-loop not reached within %0d cycles", MAX_CYCLES);
    end
    report_test("reset_start", err_reset);
    report_test("bus_stable", err_bus);
    assert (exp_addr_q.size() == 0) else begin
      err_store++;
      $display("store_order: %0d expected writes never reached the bus", exp_addr_q.size());
    end
    report_test("store_order", err_store);
    check_dump();
    report_test("dump_values", err_dump);
    report_test("x0_zero", err_x0);
    report_test("control_flow", err_flow);
    total = err_reset + err_bus + err_store + err_dump + err_x0 + err_flow;
    $display("summary: 6 tests, %0d failed, %0d errors", failed_tests, total);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verification
rtl/ceres_pkg.sv
rtl/reg_file.sv
rtl/decoder.sv
rtl/fetch_unit.sv
rtl/execute_unit.sv
rtl/load_store_unit.sv
rtl/memory_arbiter.sv
rtl/cpu_top.sv
verification/cpu_tb.sv

// ==== Makefile ====
SIM        := verilator
TOP        := cpu_tb
LINT_TOP   := cpu_top
FILELIST   := compile.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all run lint clean

all: run

run:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
